// File: source/vp_input_defines.svh
`ifndef VP_INPUT_DEFINES_SVH
`define VP_INPUT_DEFINES_SVH

// Field widths
`define VP_SCAN_W          9
`define VP_NUMPAD_W        10
`define VP_JOY_W           16

// PS/2 event word, scan code sits in the low bits
`define VP_PS2_TOGGLE      10
`define VP_PS2_PRESSED     9

// Joystick word, buttons active high
`define VP_JOY_RIGHT       0
`define VP_JOY_LEFT        1
`define VP_JOY_DOWN        2
`define VP_JOY_UP          3
`define VP_JOY_ACTION      4
`define VP_JOY_RESET       5
`define VP_JOY_NUMPAD_LSB  6   // Ten numpad buttons above this

// Special keymap codes
`define VP_ASCII_NONE      8'h00
`define VP_ASCII_YES       8'h11
`define VP_ASCII_NO        8'h12
`define VP_ASCII_ENTER     8'h0A
`define VP_ASCII_BKSP      8'h08
`endif

// File: source/vp_input_pkg.sv
`include "vp_input_defines.svh"

package vp_input_pkg;

	typedef logic [7:0]                ascii_t;      // Keymap code
	typedef logic [`VP_SCAN_W-1:0]     scan_code_t;  // Extended flag on top
	typedef logic [`VP_NUMPAD_W-1:0]   numpad_t;
	typedef logic [`VP_JOY_W-1:0]      joy_word_t;

	// Toggle, pressed, then scan code
	typedef logic [`VP_PS2_TOGGLE:0]   ps2_event_t;

	// Bit 1 is player A, bit 0 is player B
	typedef logic [1:0]                player_pair_t;

	// Key offer to the keymap
	typedef enum logic {
		DLV_IDLE,
		DLV_OFFER
	} delivery_state_e;

endpackage

// File: source/vp_raw_key_if.sv
`include "vp_input_defines.svh"

// Raw key event, capture to translate
interface vp_raw_key_if;

	logic                     valid;
	logic                     ready;
	logic                     is_ps2;     // Else numpad event
	vp_input_pkg::scan_code_t scan_code;
	vp_input_pkg::numpad_t    numpad;     // Both players ORed
	logic                     released;

	modport capture (
		output valid, is_ps2, scan_code, numpad, released,
		input  ready
	);

	modport translate (
		input  valid, is_ps2, scan_code, numpad, released,
		output ready
	);

endinterface

// File: source/vp_ascii_key_if.sv
`include "vp_input_defines.svh"

// Translated key, translate to delivery
interface vp_ascii_key_if;

	logic                 valid;
	logic                 ready;
	vp_input_pkg::ascii_t ascii;
	logic                 released;

	modport translate (
		output valid, ascii, released,
		input  ready
	);

	modport delivery (
		input  valid, ascii, released,
		output ready
	);

endinterface

// File: source/vp_key_capture.sv
`include "vp_input_defines.svh"

module vp_key_capture (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  vp_input_pkg::ps2_event_t   ps2_key_i,
	input  vp_input_pkg::joy_word_t    joy_a_i,
	input  vp_input_pkg::joy_word_t    joy_b_i,
	input  logic                       swap_i,
	output vp_input_pkg::player_pair_t joy_up_n_o,
	output vp_input_pkg::player_pair_t joy_down_n_o,
	output vp_input_pkg::player_pair_t joy_left_n_o,
	output vp_input_pkg::player_pair_t joy_right_n_o,
	output vp_input_pkg::player_pair_t joy_action_n_o,
	output logic                       console_reset_n_o,
	vp_raw_key_if.capture              raw
);

	vp_input_pkg::joy_word_t joy_a, joy_b;
	vp_input_pkg::numpad_t   numpad, old_numpad;
	logic                    old_toggle;
	logic                    ps2_hit, pad_hit;
	logic                    slot_free;

	//////////////////// Joysticks

	assign joy_a = swap_i ? joy_b_i : joy_a_i;
	assign joy_b = swap_i ? joy_a_i : joy_b_i;

	// Console wants low when pressed
	assign joy_up_n_o     = {~joy_a[`VP_JOY_UP],     ~joy_b[`VP_JOY_UP]};
	assign joy_down_n_o   = {~joy_a[`VP_JOY_DOWN],   ~joy_b[`VP_JOY_DOWN]};
	assign joy_left_n_o   = {~joy_a[`VP_JOY_LEFT],   ~joy_b[`VP_JOY_LEFT]};
	assign joy_right_n_o  = {~joy_a[`VP_JOY_RIGHT],  ~joy_b[`VP_JOY_RIGHT]};
	assign joy_action_n_o = {~joy_a[`VP_JOY_ACTION], ~joy_b[`VP_JOY_ACTION]};
	assign console_reset_n_o = ~(joy_a[`VP_JOY_RESET] | joy_b[`VP_JOY_RESET]);

	//////////////////// Event detect

	assign numpad = joy_a[`VP_JOY_NUMPAD_LSB +: `VP_NUMPAD_W]
		| joy_b[`VP_JOY_NUMPAD_LSB +: `VP_NUMPAD_W];

	assign ps2_hit   = ps2_key_i[`VP_PS2_TOGGLE] != old_toggle;
	assign pad_hit   = numpad != old_numpad;
	assign slot_free = ~raw.valid | raw.ready; // Events while full are lost

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_toggle <= 1'b0;
			old_numpad <= '0;
			raw.valid  <= 1'b0;
		end else begin
			old_toggle <= ps2_key_i[`VP_PS2_TOGGLE];
			old_numpad <= numpad;
			if (slot_free)
				raw.valid <= ps2_hit | pad_hit;
		end
	end

	// PS/2 wins a tie with the numpad
	always_ff @(posedge clk_sys) begin
		if (slot_free && (ps2_hit || pad_hit)) begin
			raw.is_ps2    <= ps2_hit;
			raw.scan_code <= ps2_key_i[`VP_SCAN_W-1:0];
			raw.numpad    <= numpad;
			raw.released  <= ps2_hit ? ~ps2_key_i[`VP_PS2_PRESSED] : (numpad == '0);
		end
	end

	a_valid_held: assert property (@(posedge clk_sys) disable iff (reset)
		raw.valid && !raw.ready |=> raw.valid)
		else $error("raw key valid dropped without a transfer");

endmodule

// File: source/vp_key_translate.sv
`include "vp_input_defines.svh"

module vp_key_translate (
	input  logic             clk_sys,
	input  logic             reset,
	vp_raw_key_if.translate  raw,
	vp_ascii_key_if.translate key
);

	vp_input_pkg::ascii_t ps2_ascii, pad_ascii;
	vp_input_pkg::ascii_t last_digit;   // Replayed on numpad release
	logic                 take;

	// Extended flag does not matter here
	function automatic vp_input_pkg::ascii_t ps2_to_ascii(input vp_input_pkg::scan_code_t code);
		vp_input_pkg::ascii_t a;
		case (code[7:0])
			8'h16: a = "1";
			8'h1E: a = "2";
			8'h26: a = "3";
			8'h25: a = "4";
			8'h2E: a = "5";
			8'h36: a = "6";
			8'h3D: a = "7";
			8'h3E: a = "8";
			8'h46: a = "9";
			8'h45: a = "0";
			8'h1C: a = "a";
			8'h32: a = "b";
			8'h21: a = "c";
			8'h23: a = "d";
			8'h24: a = "e";
			8'h2B: a = "f";
			8'h34: a = "g";
			8'h33: a = "h";
			8'h43: a = "i";
			8'h3B: a = "j";
			8'h42: a = "k";
			8'h4B: a = "l";
			8'h3A: a = "m";
			8'h31: a = "n";
			8'h44: a = "o";
			8'h4D: a = "p";
			8'h15: a = "q";
			8'h2D: a = "r";
			8'h1B: a = "s";
			8'h2C: a = "t";
			8'h3C: a = "u";
			8'h2A: a = "v";
			8'h1D: a = "w";
			8'h22: a = "x";
			8'h35: a = "y";
			8'h1A: a = "z";
			8'h29: a = " ";
			8'h79: a = "+";
			8'h7B: a = "-";
			8'h7C: a = "*";
			8'h4A: a = "/";
			8'h55: a = "=";
			8'h1F: a = `VP_ASCII_YES;   // Left GUI
			8'h27: a = `VP_ASCII_NO;    // Right GUI
			8'h5A: a = `VP_ASCII_ENTER;
			8'h66: a = `VP_ASCII_BKSP;
			default: a = `VP_ASCII_NONE;
		endcase
		return a;
	endfunction

	// Lowest button wins, button 9 is the zero key
	function automatic vp_input_pkg::ascii_t numpad_to_ascii(input vp_input_pkg::numpad_t pad);
		vp_input_pkg::ascii_t a;
		a = `VP_ASCII_NONE;
		for (int i = `VP_NUMPAD_W - 1; i >= 0; i--) begin
			if (pad[i])
				a = (i == `VP_NUMPAD_W - 1) ? 8'("0") : 8'("1" + i);
		end
		return a;
	endfunction

	assign raw.ready = ~key.valid | key.ready;
	assign take      = raw.valid & raw.ready;
	assign ps2_ascii = ps2_to_ascii(raw.scan_code);
	assign pad_ascii = raw.released ? last_digit : numpad_to_ascii(raw.numpad);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key.valid  <= 1'b0;
			last_digit <= `VP_ASCII_NONE;
		end else begin
			if (raw.ready)
				key.valid <= raw.valid;
			if (take && !raw.is_ps2 && !raw.released)
				last_digit <= pad_ascii;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			key.ascii    <= raw.is_ps2 ? ps2_ascii : pad_ascii;
			key.released <= raw.released;
		end
	end

endmodule

// File: source/vp_key_delivery.sv
`include "vp_input_defines.svh"

module vp_key_delivery (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 keyb_read_i,
	output logic                 key_ready_o,
	output vp_input_pkg::ascii_t key_ascii_o,
	output logic                 key_released_o,
	vp_ascii_key_if.delivery     key
);

	vp_input_pkg::delivery_state_e state;
	logic                          take;

	// Next key may slip in on the read edge
	assign key.ready   = (state == vp_input_pkg::DLV_IDLE) | keyb_read_i;
	assign take        = key.valid & key.ready;
	assign key_ready_o = state == vp_input_pkg::DLV_OFFER;

	//////////////////// Offer FSM

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= vp_input_pkg::DLV_IDLE;
		end else begin
			case (state)
				vp_input_pkg::DLV_IDLE: begin
					if (take)
						state <= vp_input_pkg::DLV_OFFER;
				end
				vp_input_pkg::DLV_OFFER: begin
					if (keyb_read_i && !take)
						state <= vp_input_pkg::DLV_IDLE; // Read, nothing waiting
				end
				default: state <= vp_input_pkg::DLV_IDLE;
			endcase
		end
	end

	// Held for the keymap until read
	always_ff @(posedge clk_sys) begin
		if (take) begin
			key_ascii_o    <= key.ascii;
			key_released_o <= key.released;
		end
	end

	a_offer_stable: assert property (@(posedge clk_sys) disable iff (reset)
		key_ready_o && !keyb_read_i |=> key_ready_o && $stable(key_ascii_o))
		else $error("offered key changed before it was read");

endmodule

// File: source/vp_input_top.sv
`include "vp_input_defines.svh"

module vp_input_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  vp_input_pkg::ps2_event_t   ps2_key_i,
	input  vp_input_pkg::joy_word_t    joy_a_i,
	input  vp_input_pkg::joy_word_t    joy_b_i,
	input  logic                       swap_i,
	input  logic                       keyb_read_i,
	output vp_input_pkg::player_pair_t joy_up_n_o,
	output vp_input_pkg::player_pair_t joy_down_n_o,
	output vp_input_pkg::player_pair_t joy_left_n_o,
	output vp_input_pkg::player_pair_t joy_right_n_o,
	output vp_input_pkg::player_pair_t joy_action_n_o,
	output logic                       console_reset_n_o,
	output logic                       key_ready_o,
	output vp_input_pkg::ascii_t       key_ascii_o,
	output logic                       key_released_o
);

	vp_raw_key_if   raw_if ();
	vp_ascii_key_if key_if ();

	//////////////////// Key pipeline

	vp_key_capture capture_i (
		.clk_sys, .reset,
		.ps2_key_i, .joy_a_i, .joy_b_i, .swap_i,
		.joy_up_n_o, .joy_down_n_o, .joy_left_n_o, .joy_right_n_o,
		.joy_action_n_o, .console_reset_n_o,
		.raw (raw_if.capture)
	);

	vp_key_translate translate_i (
		.clk_sys, .reset,
		.raw (raw_if.translate),
		.key (key_if.translate)
	);

	// Keymap side handshake
	vp_key_delivery delivery_i (
		.clk_sys, .reset,
		.keyb_read_i, .key_ready_o, .key_ascii_o, .key_released_o,
		.key (key_if.delivery)
	);

endmodule

// File: tb/tb_vp_input.sv
module tb_vp_input;

	typedef struct packed {
		logic [1:0]  kind;      // 0 PS/2, 1 numpad, 2 lines only
		logic [8:0]  code;
		logic        pressed;
		logic [15:0] joy_a;
		logic [15:0] joy_b;
		logic        swap;
		logic [3:0]  delay;     // Cycles before the read
		logic [7:0]  ascii;
		logic        released;
		logic [1:0]  up, down, left, right, action;
		logic        reset_n;
	} test_vec_t;

	logic clk_sys, reset, swap_i, keyb_read_i, toggle;
	logic console_reset_n_o, key_ready_o, key_released_o;
	vp_input_pkg::ps2_event_t   ps2_key_i;
	vp_input_pkg::joy_word_t    joy_a_i, joy_b_i;
	vp_input_pkg::player_pair_t joy_up_n_o, joy_down_n_o, joy_left_n_o;
	vp_input_pkg::player_pair_t joy_right_n_o, joy_action_n_o;
	vp_input_pkg::ascii_t       key_ascii_o;

	test_vec_t   golden_q[$];
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int          test_num, test_errors;
	int          pass_count = 0;
	int          fail_count = 0;
	logic [31:0] rnd = 32'd7;

	vp_input_top dut_i (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	//////////////////// Timeout

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			$display("Timeout: test %0d still waiting after %0d cycles", test_num, cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////// Helpers

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bit load_golden();
		int    fd, n;
		int    f[15];
		string line;
		fd = $fopen("tb/vp_input_golden.txt", "r");
		if (fd == 0)
			return 1'b0;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14]);
				if (n == 15)
					golden_q.push_back({f[0][1:0], f[1][8:0], f[2][0],
						f[3][15:0], f[4][15:0], f[5][0], f[6][3:0],
						f[7][7:0], f[8][0], f[9][1:0], f[10][1:0], f[11][1:0],
						f[12][1:0], f[13][1:0], f[14][0]});
			end
		end
		$fclose(fd);
		return golden_q.size() > 0;
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAILED test %0d %s got %h expected %h", test_num, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_lines(input test_vec_t v);
		check_hex("joy_up_n_o", 8'(joy_up_n_o), 8'(v.up));
		check_hex("joy_down_n_o", 8'(joy_down_n_o), 8'(v.down));
		check_hex("joy_left_n_o", 8'(joy_left_n_o), 8'(v.left));
		check_hex("joy_right_n_o", 8'(joy_right_n_o), 8'(v.right));
		check_hex("joy_action_n_o", 8'(joy_action_n_o), 8'(v.action));
		check_hex("console_reset_n_o", 8'(console_reset_n_o), 8'(v.reset_n));
	endtask

	//////////////////// Driver and checker

	task automatic run_test(input test_vec_t v);
		test_errors = 0;
		if (v.kind == 2'd0)
			toggle = ~toggle;   // New PS/2 event
		ps2_key_i = {toggle, v.pressed, v.code};
		joy_a_i   = v.joy_a;
		joy_b_i   = v.joy_b;
		swap_i    = v.swap;
		tick();
		if (v.kind == 2'd2) begin
			check_lines(v);
		end else begin
			while (key_ready_o !== 1'b1)
				tick();
			check_hex("key_ascii_o", key_ascii_o, v.ascii);
			check_hex("key_released_o", 8'(key_released_o), 8'(v.released));
			check_lines(v);
			repeat (v.delay) begin
				tick();
				if (key_ready_o !== 1'b1) begin
					$display("Test %0d: key ready dropped before the keymap read it", test_num);
					test_errors++;
				end
				check_hex("key_ascii_o", key_ascii_o, v.ascii);
			end
			keyb_read_i = 1'b1;
			tick();
			keyb_read_i = 1'b0;
			while (key_ready_o !== 1'b0)
				tick();
		end
		rnd = next_random(rnd);
		repeat (rnd[17:16]) tick();   // Idle gap of 0 to 3 cycles
		if (test_errors == 0) begin
			pass_count++;
			$display("Test %0d kind %0d: ok", test_num, v.kind);
		end else begin
			fail_count++;
			$display("Test %0d kind %0d: %0d errors", test_num, v.kind, test_errors);
		end
	endtask

	initial begin
		reset       = 1'b1;
		ps2_key_i   = '0;
		joy_a_i     = '0;
		joy_b_i     = '0;
		swap_i      = 1'b0;
		keyb_read_i = 1'b0;
		toggle      = 1'b0;
		test_num    = 0;
		if (!load_golden()) begin
			$display("Golden file tb/vp_input_golden.txt missing or empty");
			$display("Simulation failed");
		end else begin
			cycle_limit = 10 + 40 * golden_q.size();
			repeat (10) @(posedge clk_sys);
			#2 reset = 1'b0;
			foreach (golden_q[i]) begin
				test_num = i + 1;
				run_test(golden_q[i]);
			end
			$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
			if (fail_count == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+source
source/vp_input_pkg.sv
source/vp_raw_key_if.sv
source/vp_ascii_key_if.sv
source/vp_key_capture.sv
source/vp_key_translate.sv
source/vp_key_delivery.sv
source/vp_input_top.sv
tb/tb_vp_input.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f src.f --top-module tb_vp_input; then
	echo "Verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/Vtb_vp_input 2>&1); then
	printf '%s\n' "$out"
	echo "Simulation binary returned an error status"
	exit 1
fi
printf '%s\n' "$out"

# Only the pass line counts as success
if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

// File: tb/vp_input_golden.txt
# kind(0 ps2,1 numpad,2 lines) code pressed joy_a joy_b swap read_delay
# exp: ascii released up_n down_n left_n right_n action_n console_reset_n
0 01C 1 0000 0000 0 0 61 0 3 3 3 3 3 1
0 02E 1 0000 0000 0 0 35 0 3 3 3 3 3 1
0 05A 1 0000 0000 0 0 0A 0 3 3 3 3 3 1
0 127 1 0000 0000 0 0 12 0 3 3 3 3 3 1
0 11C 1 0000 0000 0 0 61 0 3 3 3 3 3 1
0 01C 0 0000 0000 0 0 61 1 3 3 3 3 3 1
0 007 1 0000 0000 0 0 00 0 3 3 3 3 3 1
0 079 1 0000 0000 0 0 2B 0 3 3 3 3 3 1
1 000 0 0000 2200 0 0 34 0 3 3 3 3 3 1
1 000 0 0000 0000 0 0 34 1 3 3 3 3 3 1
2 000 0 0018 0000 1 0 00 0 2 3 3 3 2 1
2 000 0 0018 0000 0 0 00 0 1 3 3 3 1 1
1 000 0 0060 0000 0 0 31 0 3 3 3 3 3 0
1 000 0 0020 0000 0 0 31 1 3 3 3 3 3 0
1 000 0 0000 1020 0 0 37 0 3 3 3 3 3 0
1 000 0 0000 0000 0 0 37 1 3 3 3 3 3 1
0 01A 1 0000 0000 0 5 7A 0 3 3 3 3 3 1
1 000 0 0000 8000 0 2 30 0 3 3 3 3 3 1
